/* depth_merge.sv */
`timescale 1ns/1ns

module depth_merge (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  render_pkg::tri_setup_t setup,
    input  logic                   cov_valid,
    input  logic                   cov_hit,
    input  render_pkg::pix_xy_t    cov_xy,
    input  logic                   cov_last,
    input  logic [7:0]             rd_z,
    output logic                   wr_en,
    output render_pkg::pix_xy_t    wr_xy,
    output logic [7:0]             wr_z,
    output logic                   advance,
    output logic                   m_pix_valid,
    input  logic                   m_pix_ready,
    output render_pkg::pix_out_t   m_pix_data,
    output logic                   draw_done,
    output logic [7:0]             pix_count
);

    logic emit;
    logic m_last;
    logic fresh;

    assign advance = !(m_pix_valid && !m_pix_ready);
    assign emit    = cov_valid && cov_hit && (setup.tri_z < rd_z);
    assign wr_en   = advance && emit;
    assign wr_xy   = cov_xy;
    assign wr_z    = setup.tri_z;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_pix_valid <= 1'b0;
            m_last      <= 1'b0;
            draw_done   <= 1'b0;
            pix_count   <= '0;
            fresh       <= 1'b1;
        end else begin
            // The last item retires either on its handshake or when it is dropped here
            draw_done <= (m_pix_valid && m_pix_ready && m_last)
                      || (advance && cov_valid && cov_last && !emit);
            if (advance) begin
                m_pix_valid <= emit;
                m_last      <= emit && cov_last;
                if (cov_valid) begin
                    pix_count <= (fresh ? 8'd0 : pix_count) + {7'd0, emit};
                    fresh     <= cov_last;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (advance && emit) begin
            m_pix_data <= '{color: setup.color, y: cov_xy.y, x: cov_xy.x};
        end
    end

endmodule

/* edge_coverage.sv */
`timescale 1ns/1ns

module edge_coverage (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  render_pkg::tri_setup_t setup,
    input  logic                   advance,
    input  logic                   scan_valid,
    input  render_pkg::pix_xy_t    scan_xy,
    input  logic                   scan_last,
    output logic                   cov_valid,
    output logic                   cov_hit,
    output render_pkg::pix_xy_t    cov_xy,
    output logic                   cov_last
);

    logic signed [10:0] e01;
    logic signed [10:0] e12;
    logic signed [10:0] e20;

    // Differences fit in six signed bits and the result in eleven
    function automatic logic signed [10:0] edge_fn(
        input logic [render_pkg::scr_bits-1:0] ax, ay, bx, by, px, py);
        logic signed [render_pkg::scr_bits+1:0] dx_ab;
        logic signed [render_pkg::scr_bits+1:0] dy_ab;
        logic signed [render_pkg::scr_bits+1:0] dx_ap;
        logic signed [render_pkg::scr_bits+1:0] dy_ap;
        dx_ab = $signed({2'b00, bx}) - $signed({2'b00, ax});
        dy_ab = $signed({2'b00, by}) - $signed({2'b00, ay});
        dx_ap = $signed({2'b00, px}) - $signed({2'b00, ax});
        dy_ap = $signed({2'b00, py}) - $signed({2'b00, ay});
        edge_fn = dx_ab * dy_ap - dy_ab * dx_ap;
    endfunction

    assign e01 = edge_fn(setup.x0, setup.y0, setup.x1, setup.y1, scan_xy.x, scan_xy.y);
    assign e12 = edge_fn(setup.x1, setup.y1, setup.x2, setup.y2, scan_xy.x, scan_xy.y);
    assign e20 = edge_fn(setup.x2, setup.y2, setup.x0, setup.y0, scan_xy.x, scan_xy.y);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cov_valid <= 1'b0;
        end else if (advance) begin
            cov_valid <= scan_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (advance) begin
            cov_hit  <= (e01 >= 0) && (e12 >= 0) && (e20 >= 0);
            cov_xy   <= scan_xy;
            cov_last <= scan_last;
        end
    end

endmodule

/* irq_gen.sv */
`timescale 1ns/1ns

module irq_gen (
    input  logic aclk,
    input  logic aresetn,
    input  logic draw_done,
    output logic irq_req,
    input  logic irq_ack
);

    logic draw_done_q;
    logic irq_trigger;
    logic irq_wait;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            draw_done_q <= 1'b0;
            irq_trigger <= 1'b0;
            irq_wait    <= 1'b0;
            irq_req     <= 1'b0;
        end else begin
            draw_done_q <= draw_done;
            irq_trigger <= draw_done && !draw_done_q;
            // Once a request is out, later triggers are dropped until the host acks
            if (!irq_wait && irq_trigger) begin
                irq_wait <= 1'b1;
            end else if (irq_ack) begin
                irq_wait <= 1'b0;
            end
            irq_req <= !irq_wait && irq_trigger;
        end
    end

endmodule

/* raster_scanner.sv */
`timescale 1ns/1ns

module raster_scanner (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  render_pkg::tri_setup_t setup,
    input  logic                   draw_go,
    input  logic                   advance,
    output logic                   scan_valid,
    output render_pkg::pix_xy_t    scan_xy,
    output logic                   scan_last
);

    logic [render_pkg::scr_bits-1:0] x_min;
    logic [render_pkg::scr_bits-1:0] x_max;
    logic [render_pkg::scr_bits-1:0] y_min;
    logic [render_pkg::scr_bits-1:0] y_max;

    function automatic logic [render_pkg::scr_bits-1:0] min3(
        input logic [render_pkg::scr_bits-1:0] a, b, c);
        min3 = a;
        if (b < min3) begin
            min3 = b;
        end
        if (c < min3) begin
            min3 = c;
        end
    endfunction

    function automatic logic [render_pkg::scr_bits-1:0] max3(
        input logic [render_pkg::scr_bits-1:0] a, b, c);
        max3 = a;
        if (b > max3) begin
            max3 = b;
        end
        if (c > max3) begin
            max3 = c;
        end
    endfunction

    // Setup is held stable for the whole draw, so the box needs no registers
    assign x_min = min3(setup.x0, setup.x1, setup.x2);
    assign x_max = max3(setup.x0, setup.x1, setup.x2);
    assign y_min = min3(setup.y0, setup.y1, setup.y2);
    assign y_max = max3(setup.y0, setup.y1, setup.y2);

    assign scan_last = (scan_xy.x == x_max) && (scan_xy.y == y_max);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            scan_valid <= 1'b0;
        end else if (draw_go) begin
            scan_valid <= 1'b1;
        end else if (advance && scan_valid && scan_last) begin
            scan_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (draw_go) begin
            scan_xy <= '{y: y_min, x: x_min};
        end else if (advance && scan_valid && !scan_last) begin
            if (scan_xy.x == x_max) begin
                scan_xy.x <= x_min;
                scan_xy.y <= scan_xy.y + 1'b1;
            end else begin
                scan_xy.x <= scan_xy.x + 1'b1;
            end
        end
    end

endmodule

/* render_assertions.sv */
`timescale 1ns/1ns

module render_assertions (
    input logic                 aclk,
    input logic                 aresetn,
    input logic                 m_pix_valid,
    input logic                 m_pix_ready,
    input render_pkg::pix_out_t m_pix_data,
    input logic                 irq_req,
    input logic                 irq_ack
);

    logic irq_pending;

    // Set by a request and cleared by the host acknowledge
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            irq_pending <= 1'b0;
        end else if (irq_ack) begin
            irq_pending <= 1'b0;
        end else if (irq_req) begin
            irq_pending <= 1'b1;
        end
    end

    assert property (@(posedge aclk) disable iff (!aresetn)
        m_pix_valid && !m_pix_ready |=> m_pix_valid && $stable(m_pix_data))
        else $error("pixel stream changed while stalled");

    assert property (@(posedge aclk) disable iff (!aresetn) irq_req |=> !irq_req)
        else $error("irq_req lasted more than one cycle");

    assert property (@(posedge aclk) disable iff (!aresetn) irq_req |-> !irq_pending)
        else $error("second irq_req before irq_ack");

endmodule

bind render_top render_assertions u_assertions (
    .aclk, .aresetn, .m_pix_valid, .m_pix_ready, .m_pix_data, .irq_req, .irq_ack
);

/* render_ctrl_regs.sv */
`timescale 1ns/1ns

module render_ctrl_regs (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   s_axil_awvalid,
    output logic                   s_axil_awready,
    input  logic [5:0]             s_axil_awaddr,
    input  logic                   s_axil_wvalid,
    output logic                   s_axil_wready,
    input  logic [31:0]            s_axil_wdata,
    input  logic [3:0]             s_axil_wstrb,
    output logic                   s_axil_bvalid,
    input  logic                   s_axil_bready,
    output logic [1:0]             s_axil_bresp,
    input  logic                   s_axil_arvalid,
    output logic                   s_axil_arready,
    input  logic [5:0]             s_axil_araddr,
    output logic                   s_axil_rvalid,
    input  logic                   s_axil_rready,
    output logic [31:0]            s_axil_rdata,
    output logic [1:0]             s_axil_rresp,
    output render_pkg::tri_setup_t setup,
    output logic                   draw_go,
    output logic                   clear_go,
    input  logic                   clear_done,
    input  logic                   draw_done,
    input  logic [7:0]             pix_count
);

    typedef enum logic [1:0] {st_idle, st_clear, st_draw} state_t;

    state_t                 state;
    logic                   start_pend;
    logic                   busy;
    logic                   ctrl_wr;
    logic                   launch;
    render_pkg::vertex_t    v0;
    render_pkg::vertex_t    v1;
    render_pkg::vertex_t    v2;
    logic [7:0]             color;
    logic [7:0]             min_z;
    logic [31:0]            old_word;
    logic [31:0]            wmask;
    render_pkg::reg_word_u  wword;

    function automatic render_pkg::vertex_t clean_vtx(input render_pkg::vertex_t v);
        clean_vtx = '0;
        clean_vtx.x = v.x;
        clean_vtx.y = v.y;
        clean_vtx.z = v.z;
    endfunction

    assign s_axil_bresp = 2'b00;
    assign s_axil_rresp = 2'b00;

    // Byte strobes merge the new data into the register's current value
    always_comb begin
        case (s_axil_awaddr)
            render_pkg::reg_v0:    old_word = v0;
            render_pkg::reg_v1:    old_word = v1;
            render_pkg::reg_v2:    old_word = v2;
            render_pkg::reg_color: old_word = {24'd0, color};
            default:               old_word = '0;
        endcase
    end

    assign wmask = {{8{s_axil_wstrb[3]}}, {8{s_axil_wstrb[2]}},
                    {8{s_axil_wstrb[1]}}, {8{s_axil_wstrb[0]}}};
    assign wword = (old_word & ~wmask) | (s_axil_wdata & wmask);

    // The address and data are committed on the cycle awready is high
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_bvalid  <= 1'b0;
            s_axil_arready <= 1'b0;
            s_axil_rvalid  <= 1'b0;
        end else begin
            s_axil_awready <= s_axil_awvalid & s_axil_wvalid & ~s_axil_awready & ~s_axil_bvalid;
            s_axil_wready  <= s_axil_awvalid & s_axil_wvalid & ~s_axil_awready & ~s_axil_bvalid;
            s_axil_arready <= s_axil_arvalid & ~s_axil_arready & ~s_axil_rvalid;
            if (s_axil_awready) begin
                s_axil_bvalid <= 1'b1;
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
            if (s_axil_arready) begin
                s_axil_rvalid <= 1'b1;
            end else if (s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (s_axil_arready) begin
            case (s_axil_araddr)
                render_pkg::reg_status: s_axil_rdata <= {16'd0, pix_count, 7'd0, busy};
                render_pkg::reg_v0:     s_axil_rdata <= v0;
                render_pkg::reg_v1:     s_axil_rdata <= v1;
                render_pkg::reg_v2:     s_axil_rdata <= v2;
                render_pkg::reg_color:  s_axil_rdata <= {24'd0, color};
                default:                s_axil_rdata <= '0;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            v0    <= '0;
            v1    <= '0;
            v2    <= '0;
            color <= '0;
        end else if (s_axil_awready) begin
            case (s_axil_awaddr)
                render_pkg::reg_v0:    v0 <= clean_vtx(wword.vtx);
                render_pkg::reg_v1:    v1 <= clean_vtx(wword.vtx);
                render_pkg::reg_v2:    v2 <= clean_vtx(wword.vtx);
                render_pkg::reg_color: color <= wword[7:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        min_z = v0.z;
        if (v1.z < min_z) begin
            min_z = v1.z;
        end
        if (v2.z < min_z) begin
            min_z = v2.z;
        end
    end

    assign ctrl_wr = s_axil_awready && (s_axil_awaddr == render_pkg::reg_ctrl);
    assign launch  = (state == st_idle && ctrl_wr && wword.ctrl.start && !wword.ctrl.clear_zbuf)
                  || (state == st_clear && clear_done && start_pend);

    // Busy drops on the draw_done cycle itself
    assign busy = (state != st_idle) && !draw_done;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state      <= st_idle;
            start_pend <= 1'b0;
            draw_go    <= 1'b0;
            clear_go   <= 1'b0;
        end else begin
            draw_go  <= launch;
            clear_go <= 1'b0;
            case (state)
                st_idle: begin
                    if (ctrl_wr && wword.ctrl.clear_zbuf) begin
                        clear_go   <= 1'b1;
                        start_pend <= wword.ctrl.start;
                        state      <= st_clear;
                    end else if (launch) begin
                        state <= st_draw;
                    end
                end
                st_clear: begin
                    if (clear_done) begin
                        state <= start_pend ? st_draw : st_idle;
                    end
                end
                default: begin
                    if (draw_done) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (launch) begin
            setup <= '{x0: v0.x, y0: v0.y, x1: v1.x, y1: v1.y, x2: v2.x, y2: v2.y,
                       tri_z: min_z, color: color};
        end
    end

endmodule

/* render_pkg.sv */
package render_pkg;

    // The screen is 16 by 16, so one coordinate fits in four bits
    localparam int scr_bits = 4;
    localparam int zbuf_depth = 256;

    localparam logic [5:0] reg_ctrl   = 6'h00;
    localparam logic [5:0] reg_status = 6'h04;
    localparam logic [5:0] reg_v0     = 6'h08;
    localparam logic [5:0] reg_v1     = 6'h0C;
    localparam logic [5:0] reg_v2     = 6'h10;
    localparam logic [5:0] reg_color  = 6'h14;

    typedef struct packed {
        logic [7:0]          rsvd_hi;
        logic [7:0]          z;
        logic [3:0]          rsvd_y;
        logic [scr_bits-1:0] y;
        logic [3:0]          rsvd_x;
        logic [scr_bits-1:0] x;
    } vertex_t;

    typedef struct packed {
        logic [29:0] rsvd;
        logic        clear_zbuf;
        logic        start;
    } ctrl_t;

    // One bus write word, seen as a vertex or as a control word by address
    typedef union packed {
        vertex_t vtx;
        ctrl_t   ctrl;
    } reg_word_u;

    typedef struct packed {
        logic [scr_bits-1:0] x0;
        logic [scr_bits-1:0] y0;
        logic [scr_bits-1:0] x1;
        logic [scr_bits-1:0] y1;
        logic [scr_bits-1:0] x2;
        logic [scr_bits-1:0] y2;
        logic [7:0]          tri_z;
        logic [7:0]          color;
    } tri_setup_t;

    // Packed with y on top so the struct doubles as the z-buffer address
    typedef struct packed {
        logic [scr_bits-1:0] y;
        logic [scr_bits-1:0] x;
    } pix_xy_t;

    typedef struct packed {
        logic [7:0]          color;
        logic [scr_bits-1:0] y;
        logic [scr_bits-1:0] x;
    } pix_out_t;

endpackage

/* render_top.sv */
`timescale 1ns/1ns

module render_top (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 s_axil_awvalid,
    output logic                 s_axil_awready,
    input  logic [5:0]           s_axil_awaddr,
    input  logic                 s_axil_wvalid,
    output logic                 s_axil_wready,
    input  logic [31:0]          s_axil_wdata,
    input  logic [3:0]           s_axil_wstrb,
    output logic                 s_axil_bvalid,
    input  logic                 s_axil_bready,
    output logic [1:0]           s_axil_bresp,
    input  logic                 s_axil_arvalid,
    output logic                 s_axil_arready,
    input  logic [5:0]           s_axil_araddr,
    output logic                 s_axil_rvalid,
    input  logic                 s_axil_rready,
    output logic [31:0]          s_axil_rdata,
    output logic [1:0]           s_axil_rresp,
    output logic                 m_pix_valid,
    input  logic                 m_pix_ready,
    output render_pkg::pix_out_t m_pix_data,
    output logic                 irq_req,
    input  logic                 irq_ack
);

    render_pkg::tri_setup_t setup;
    render_pkg::pix_xy_t    scan_xy;
    render_pkg::pix_xy_t    cov_xy;
    render_pkg::pix_xy_t    wr_xy;
    logic                   draw_go;
    logic                   clear_go;
    logic                   clear_done;
    logic                   draw_done;
    logic [7:0]             pix_count;
    logic                   advance;
    logic                   scan_valid;
    logic                   scan_last;
    logic                   cov_valid;
    logic                   cov_hit;
    logic                   cov_last;
    logic                   wr_en;
    logic [7:0]             wr_z;
    logic [7:0]             rd_z;

    render_ctrl_regs u_regs (
        .aclk, .aresetn,
        .s_axil_awvalid, .s_axil_awready, .s_axil_awaddr,
        .s_axil_wvalid, .s_axil_wready, .s_axil_wdata, .s_axil_wstrb,
        .s_axil_bvalid, .s_axil_bready, .s_axil_bresp,
        .s_axil_arvalid, .s_axil_arready, .s_axil_araddr,
        .s_axil_rvalid, .s_axil_rready, .s_axil_rdata, .s_axil_rresp,
        .setup, .draw_go, .clear_go, .clear_done, .draw_done, .pix_count
    );

    raster_scanner u_scan (
        .aclk, .aresetn, .setup, .draw_go, .advance, .scan_valid, .scan_xy, .scan_last
    );

    edge_coverage u_cov (
        .aclk, .aresetn, .setup, .advance, .scan_valid, .scan_xy, .scan_last,
        .cov_valid, .cov_hit, .cov_xy, .cov_last
    );

    zbuf_fetch u_zbuf (
        .aclk, .aresetn, .advance, .scan_xy, .clear_go, .clear_done,
        .wr_en, .wr_xy, .wr_z, .rd_z
    );

    depth_merge u_merge (
        .aclk, .aresetn, .setup, .cov_valid, .cov_hit, .cov_xy, .cov_last, .rd_z,
        .wr_en, .wr_xy, .wr_z, .advance, .m_pix_valid, .m_pix_ready, .m_pix_data,
        .draw_done, .pix_count
    );

    irq_gen u_irq (
        .aclk, .aresetn, .draw_done, .irq_req, .irq_ack
    );

endmodule

/* run.sh */
#!/bin/sh
# Build and run the rasterizer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_render -f src.f \
    --Mdir obj_dir -o tb_render_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_render_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

/* src.f */
render_pkg.sv
irq_gen.sv
zbuf_fetch.sv
raster_scanner.sv
edge_coverage.sv
depth_merge.sv
render_ctrl_regs.sv
render_top.sv
render_assertions.sv
tb_render.sv

/* tb_render.sv */
`timescale 1ns/1ns

module tb_render;

    localparam int clk_half = 50;
    localparam int num_tests = 7;
    // This draw's request is left unacknowledged, so the next draw raises none
    localparam int held_entry = 4;
    // Clear, full box of pixels at eight cycles each, and register traffic
    localparam longint watchdog_ns = num_tests * (256 + 256 * 8 + 200) * 2 * clk_half;

    typedef struct packed {
        logic [3:0] x;
        logic [3:0] y;
        logic [7:0] z;
    } corner_t;

    typedef struct packed {
        corner_t    v0;
        corner_t    v1;
        corner_t    v2;
        logic [7:0] color;
        logic       clear;
        logic [7:0] count;
    } tri_entry_t;

    logic                 aclk;
    logic                 aresetn;
    logic                 s_axil_awvalid;
    logic                 s_axil_awready;
    logic [5:0]           s_axil_awaddr;
    logic                 s_axil_wvalid;
    logic                 s_axil_wready;
    logic [31:0]          s_axil_wdata;
    logic [3:0]           s_axil_wstrb;
    logic                 s_axil_bvalid;
    logic                 s_axil_bready;
    logic [1:0]           s_axil_bresp;
    logic                 s_axil_arvalid;
    logic                 s_axil_arready;
    logic [5:0]           s_axil_araddr;
    logic                 s_axil_rvalid;
    logic                 s_axil_rready;
    logic [31:0]          s_axil_rdata;
    logic [1:0]           s_axil_rresp;
    logic                 m_pix_valid;
    logic                 m_pix_ready;
    render_pkg::pix_out_t m_pix_data;
    logic                 irq_req;
    logic                 irq_ack;

    tri_entry_t           tests [num_tests];
    render_pkg::pix_out_t exp_q [$];
    logic [7:0]           zref [256];
    int                   irq_count;

    render_top dut (.*);

    initial begin
        aclk = 1'b0;
        forever #(clk_half) aclk = ~aclk;
    end

    initial begin
        #(watchdog_ns);
        $display("ERRORS FOUND");
        $fatal(1, "Timeout: the draws did not finish within %0d ns", watchdog_ns);
    end

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "Check failed");
    endtask

    function automatic int edge_val(input int ax, ay, bx, by, px, py);
        return (bx - ax) * (py - ay) - (by - ay) * (px - ax);
    endfunction

    function automatic render_pkg::reg_word_u vertex_word(input corner_t v);
        render_pkg::reg_word_u w;
        w.vtx.rsvd_hi = 8'hA5;
        w.vtx.z = v.z;
        w.vtx.rsvd_y = 4'hC;
        w.vtx.y = v.y;
        w.vtx.rsvd_x = 4'h3;
        w.vtx.x = v.x;
        return w;
    endfunction

    function automatic render_pkg::reg_word_u ctrl_word(input logic start, input logic clear);
        render_pkg::reg_word_u w;
        w = '0;
        w.ctrl.start = start;
        w.ctrl.clear_zbuf = clear;
        return w;
    endfunction

    // Reference model of one draw that also updates the model z-buffer
    task automatic build_expected(input tri_entry_t e);
        int x_min;
        int x_max;
        int y_min;
        int y_max;
        logic [7:0] tz;
        int a;
        int b;
        int c;
        render_pkg::pix_out_t p;
        x_min = e.v0.x < e.v1.x ? e.v0.x : e.v1.x;
        x_min = e.v2.x < x_min ? e.v2.x : x_min;
        x_max = e.v0.x > e.v1.x ? e.v0.x : e.v1.x;
        x_max = e.v2.x > x_max ? e.v2.x : x_max;
        y_min = e.v0.y < e.v1.y ? e.v0.y : e.v1.y;
        y_min = e.v2.y < y_min ? e.v2.y : y_min;
        y_max = e.v0.y > e.v1.y ? e.v0.y : e.v1.y;
        y_max = e.v2.y > y_max ? e.v2.y : y_max;
        tz = e.v0.z < e.v1.z ? e.v0.z : e.v1.z;
        tz = e.v2.z < tz ? e.v2.z : tz;
        if (e.clear) begin
            for (int i = 0; i < 256; i++) begin
                zref[i] = 8'hFF;
            end
        end
        for (int py = y_min; py <= y_max; py++) begin
            for (int px = x_min; px <= x_max; px++) begin
                a = edge_val(e.v0.x, e.v0.y, e.v1.x, e.v1.y, px, py);
                b = edge_val(e.v1.x, e.v1.y, e.v2.x, e.v2.y, px, py);
                c = edge_val(e.v2.x, e.v2.y, e.v0.x, e.v0.y, px, py);
                if (a >= 0 && b >= 0 && c >= 0 && tz < zref[py * 16 + px]) begin
                    p.color = e.color;
                    p.y = 4'(py);
                    p.x = 4'(px);
                    exp_q.push_back(p);
                    zref[py * 16 + px] = tz;
                end
            end
        end
    endtask

    task automatic axil_write(input logic [5:0] addr, input logic [31:0] data);
        s_axil_awaddr = addr;
        s_axil_wdata = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid = 1'b1;
        do @(negedge aclk); while (!s_axil_awready);
        assert (s_axil_wready)
            else report_fail($sformatf("wready did not pulse with awready at address %h", addr));
        @(negedge aclk);
        s_axil_awvalid = 1'b0;
        s_axil_wvalid = 1'b0;
        assert (s_axil_bvalid && s_axil_bresp == 2'b00)
            else report_fail($sformatf("bad write response at address %h", addr));
        @(negedge aclk);
    endtask

    task automatic axil_read(input logic [5:0] addr, output logic [31:0] data);
        s_axil_araddr = addr;
        s_axil_arvalid = 1'b1;
        do @(negedge aclk); while (!s_axil_arready);
        @(negedge aclk);
        s_axil_arvalid = 1'b0;
        assert (s_axil_rvalid && s_axil_rresp == 2'b00)
            else report_fail($sformatf("bad read response at address %h", addr));
        data = s_axil_rdata;
    endtask

    task automatic check_read(input logic [5:0] addr, input logic [31:0] expected);
        logic [31:0] got;
        axil_read(addr, got);
        assert (got == expected)
            else report_fail($sformatf("read %h got %h expected %h", addr, got, expected));
    endtask

    // Polls STATUS until the busy bit is low
    task automatic wait_idle();
        logic [31:0] st;
        st = 32'd1;
        while (st[0]) begin
            axil_read(render_pkg::reg_status, st);
        end
    endtask

    // Output sink with random back-pressure that checks every accepted pixel
    initial begin : pixel_sink
        render_pkg::pix_out_t want;
        m_pix_ready = 1'b0;
        void'($urandom(32'ha844));
        forever begin
            @(negedge aclk);
            m_pix_ready = (($urandom() & 32'h3) != 0);
            if (aresetn && m_pix_valid && m_pix_ready) begin
                assert (exp_q.size() > 0)
                    else report_fail($sformatf("unexpected pixel %h", m_pix_data));
                want = exp_q.pop_front();
                assert (m_pix_data == want)
                    else report_fail($sformatf("pixel got %h expected %h", m_pix_data, want));
            end
        end
    end

    initial begin : irq_counter
        irq_count = 0;
        forever begin
            @(negedge aclk);
            if (irq_req) begin
                irq_count++;
            end
        end
    end

    initial begin
        tri_entry_t e;
        tests[0] = '{v0: '{x: 4'd0, y: 4'd0, z: 8'd100}, v1: '{x: 4'd4, y: 4'd0, z: 8'd50},
                     v2: '{x: 4'd0, y: 4'd4, z: 8'd80}, color: 8'h3C, clear: 1'b1, count: 8'd15};
        tests[1] = '{v0: '{x: 4'd2, y: 4'd2, z: 8'd90}, v1: '{x: 4'd6, y: 4'd2, z: 8'd70},
                     v2: '{x: 4'd2, y: 4'd6, z: 8'd120}, color: 8'h81, clear: 1'b0, count: 8'd14};
        tests[2] = '{v0: '{x: 4'd2, y: 4'd2, z: 8'd90}, v1: '{x: 4'd6, y: 4'd2, z: 8'd70},
                     v2: '{x: 4'd2, y: 4'd6, z: 8'd120}, color: 8'h47, clear: 1'b1, count: 8'd15};
        tests[3] = '{v0: '{x: 4'd0, y: 4'd0, z: 8'd10}, v1: '{x: 4'd15, y: 4'd0, z: 8'd10},
                     v2: '{x: 4'd0, y: 4'd15, z: 8'd10}, color: 8'hE2, clear: 1'b0, count: 8'd136};
        // Clockwise winding covers nothing
        tests[4] = '{v0: '{x: 4'd0, y: 4'd0, z: 8'd0}, v1: '{x: 4'd0, y: 4'd4, z: 8'd0},
                     v2: '{x: 4'd4, y: 4'd0, z: 8'd0}, color: 8'h11, clear: 1'b0, count: 8'd0};
        tests[5] = '{v0: '{x: 4'd10, y: 4'd10, z: 8'd5}, v1: '{x: 4'd13, y: 4'd10, z: 8'd5},
                     v2: '{x: 4'd10, y: 4'd13, z: 8'd5}, color: 8'h9F, clear: 1'b0, count: 8'd10};
        // Equal depth fails the strict test
        tests[6] = '{v0: '{x: 4'd10, y: 4'd10, z: 8'd5}, v1: '{x: 4'd13, y: 4'd10, z: 8'd5},
                     v2: '{x: 4'd10, y: 4'd13, z: 8'd5}, color: 8'h6B, clear: 1'b0, count: 8'd0};
        aresetn = 1'b0;
        s_axil_awvalid = 1'b0;
        s_axil_awaddr = '0;
        s_axil_wvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wstrb = 4'hF;
        s_axil_bready = 1'b1;
        s_axil_arvalid = 1'b0;
        s_axil_araddr = '0;
        s_axil_rready = 1'b1;
        irq_ack = 1'b0;
        repeat (2) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        for (int i = 0; i < num_tests; i++) begin
            e = tests[i];
            build_expected(e);
            assert (exp_q.size() == int'(e.count))
                else report_fail($sformatf("entry %0d model gives %0d pixels", i, exp_q.size()));
            axil_write(render_pkg::reg_v0, vertex_word(e.v0));
            axil_write(render_pkg::reg_v1, vertex_word(e.v1));
            axil_write(render_pkg::reg_v2, vertex_word(e.v2));
            axil_write(render_pkg::reg_color, {24'h5A5A5A, e.color});
            check_read(render_pkg::reg_v0, {8'h00, e.v0.z, 4'h0, e.v0.y, 4'h0, e.v0.x});
            check_read(render_pkg::reg_v1, {8'h00, e.v1.z, 4'h0, e.v1.y, 4'h0, e.v1.x});
            check_read(render_pkg::reg_v2, {8'h00, e.v2.z, 4'h0, e.v2.y, 4'h0, e.v2.x});
            check_read(render_pkg::reg_color, {24'd0, e.color});
            check_read(render_pkg::reg_ctrl, 32'd0);
            axil_write(render_pkg::reg_ctrl, ctrl_word(1'b1, e.clear));
            check_read(render_pkg::reg_status, {16'd0, 8'(i == 0 ? 0 : tests[i - 1].count),
                                                8'd1});
            // A second start with clear while busy must leave the draw untouched
            axil_write(render_pkg::reg_ctrl, ctrl_word(1'b1, 1'b1));
            if (i == held_entry + 1) begin
                // A request would show up two cycles after draw_done
                wait_idle();
                repeat (4) @(negedge aclk);
            end else begin
                do @(negedge aclk); while (!irq_req);
            end
            if (i != held_entry) begin
                irq_ack = 1'b1;
            end
            @(negedge aclk);
            irq_ack = 1'b0;
            assert (exp_q.size() == 0)
                else report_fail($sformatf("entry %0d missing %0d pixels", i, exp_q.size()));
            assert (irq_count == i + 1 - int'(i > held_entry))
                else report_fail($sformatf("entry %0d saw %0d interrupts", i, irq_count));
            check_read(render_pkg::reg_status, {16'd0, e.count, 8'd0});
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* zbuf_fetch.sv */
`timescale 1ns/1ns

module zbuf_fetch (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                advance,
    input  render_pkg::pix_xy_t scan_xy,
    input  logic                clear_go,
    output logic                clear_done,
    input  logic                wr_en,
    input  render_pkg::pix_xy_t wr_xy,
    input  logic [7:0]          wr_z,
    output logic [7:0]          rd_z
);

    logic [7:0] mem [render_pkg::zbuf_depth];
    logic       clearing;
    logic [7:0] clr_addr;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            clearing   <= 1'b0;
            clr_addr   <= '0;
            clear_done <= 1'b0;
        end else begin
            clear_done <= 1'b0;
            if (clear_go) begin
                clearing <= 1'b1;
                clr_addr <= '0;
            end else if (clearing) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == 8'hFF) begin
                    clearing   <= 1'b0;
                    clear_done <= 1'b1;
                end
            end
        end
    end

    // Clearing never overlaps a draw, so the two writers do not collide
    always_ff @(posedge aclk) begin
        if (clearing) begin
            mem[clr_addr] <= 8'hFF;
        end else if (wr_en) begin
            mem[wr_xy] <= wr_z;
        end
    end

    always_ff @(posedge aclk) begin
        if (advance) begin
            rd_z <= mem[scan_xy];
        end
    end

endmodule
